//--- hw/vector_pkg.sv
package vector_pkg;

    // opcodes carried in bits 2:0 of a command byte
    typedef enum logic [2:0] {
        op_none  = 3'd0,  // idle marker, never accepted
        op_write = 3'd1,  // load a vector from the byte stream
        op_read  = 3'd2,  // dump the selected memory
        op_sum   = 3'd3,  // elementwise a + b
        op_man   = 3'd4,  // manhattan distance
        op_dot   = 3'd5   // dot product
    } opcode_e;           // codes 6 and 7 are unused

    localparam int elem_w   = 10;  // stored element width
    localparam int result_w = 24;  // wide enough for a 16 element dot product

    // active command as held by the decoder
    typedef struct packed {
        logic    bram_sel;  // 0 selects memory a, 1 selects memory b
        opcode_e opcode;
    } command_t;

    // engine output word
    typedef struct packed {
        logic [result_w-1:0] data;
        logic                valid;  // one cycle per result
        logic                last;   // final result of the operation
    } result_t;

endpackage

//--- hw/write_ctrl.sv
`timescale 1ns/100ps

module write_ctrl
    import vector_pkg::*;
#(
    parameter int vec_len = 16,
    localparam int addr_w = $clog2(vec_len)
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              rx_ready,    // byte strobe from the receiver
    input  logic [7:0]        rx_data,
    input  logic              write_en,    // level from the decoder
    input  logic              bram_sel,    // target memory
    output logic              wea_a,
    output logic              wea_b,
    output logic [addr_w-1:0] write_addr,
    output logic [elem_w-1:0] write_data,
    output logic              write_done   // pulse after the last element
);

    logic       high_phase;   // next data byte is the high half
    logic [7:0] low_byte;     // low half waiting for its partner
    logic       high_strobe;  // high half arriving this cycle
    logic       last_addr;    // write in flight hits the final word

    assign high_strobe = write_en && rx_ready && high_phase;
    assign last_addr   = (write_addr == addr_w'(vec_len - 1));

    // byte phase restarts with every write command
    always_ff @(posedge clk) begin
        if (reset || !write_en) begin
            high_phase <= 1'b0;
        end else if (rx_ready) begin
            high_phase <= !high_phase;  // low, high, low, high
        end
    end

    always_ff @(posedge clk) begin
        if (write_en && rx_ready && !high_phase) begin
            low_byte <= rx_data;                       // element bits 7:0
        end
        if (high_strobe) begin
            write_data <= {rx_data[1:0], low_byte};    // bits 9:8 from the high byte
        end
    end

    // one strobe per element, one cycle after the high byte
    always_ff @(posedge clk) begin
        if (reset) begin
            wea_a <= 1'b0;
            wea_b <= 1'b0;
        end else begin
            wea_a <= high_strobe && !bram_sel;
            wea_b <= high_strobe && bram_sel;
        end
    end

    // address moves on the same edge that commits the write
    always_ff @(posedge clk) begin
        if (reset || !write_en) begin
            write_addr <= '0;          // cleared before each write command
            write_done <= 1'b0;
        end else begin
            write_done <= 1'b0;
            if (wea_a || wea_b) begin
                write_addr <= last_addr ? '0 : write_addr + 1'b1;
                write_done <= last_addr;  // vec_len words stored
            end
        end
    end

endmodule

//--- hw/command_decoder.sv
`timescale 1ns/100ps

module command_decoder
    import vector_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       rx_ready,
    input  logic [7:0] rx_data,
    input  logic       write_done,  // from the write controller
    input  logic       op_done,     // from the engine
    output command_t   command,
    output logic       write_en,
    output logic       start,       // one cycle pulse for engine ops
    output logic       busy
);

    typedef enum logic [1:0] {
        idle,
        writing,   // bytes go to the write controller
        running,   // engine is walking the memories
        retire     // command cleared, next command may arrive
    } state_e;

    state_e  state;
    opcode_e rx_op;   // opcode field of the incoming byte
    logic    accept;  // valid command byte taken this cycle

    assign rx_op = opcode_e'(rx_data[2:0]);

    // data bytes and unused opcodes never get here while busy
    assign accept = rx_ready && (state == idle || state == retire)
                    && (rx_op inside {op_write, op_read, op_sum, op_man, op_dot});

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= idle;
            command <= '{bram_sel: 1'b0, opcode: op_none};
            start   <= 1'b0;
        end else begin
            start <= 1'b0;
            if (accept) begin
                command <= '{bram_sel: rx_data[7], opcode: rx_op};  // bit 7 picks a or b
                if (rx_op == op_write) begin
                    state <= writing;
                end else begin
                    state <= running;
                    start <= 1'b1;
                end
            end else begin
                case (state)
                    writing: if (write_done) state <= retire;
                    running: if (op_done) state <= retire;
                    retire: begin
                        state          <= idle;
                        command.opcode <= op_none;  // bram_sel kept, harmless
                    end
                    default: state <= idle;
                endcase
            end
        end
    end

    assign write_en = (state == writing);
    assign busy     = (state == writing) || (state == running);  // drops one cycle after done

endmodule

//--- hw/vector_bram.sv
`timescale 1ns/100ps

module vector_bram
    import vector_pkg::*;
#(
    parameter int vec_len = 16,
    localparam int addr_w = $clog2(vec_len)
) (
    input  logic              clk,
    input  logic              we,
    input  logic [addr_w-1:0] write_addr,
    input  logic [elem_w-1:0] write_data,
    input  logic [addr_w-1:0] read_addr,
    output logic [elem_w-1:0] read_data   // valid one cycle after read_addr
);

    logic [elem_w-1:0] mem [vec_len];  // infers block or distributed ram

    always_ff @(posedge clk) begin
        if (we) begin
            mem[write_addr] <= write_data;
        end
    end

    // registered read port
    always_ff @(posedge clk) begin
        read_data <= mem[read_addr];
    end

endmodule

//--- hw/input_interface.sv
`timescale 1ns/100ps

module input_interface
    import vector_pkg::*;
#(
    parameter int vec_len = 16,
    localparam int addr_w = $clog2(vec_len)
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              rx_ready,
    input  logic [7:0]        rx_data,
    input  logic [addr_w-1:0] read_addr,    // shared by both memories
    input  logic              op_done,
    output command_t          command,
    output logic              start,
    output logic              busy,
    output logic [elem_w-1:0] bram_a_dout,
    output logic [elem_w-1:0] bram_b_dout
);

    logic              write_en;
    logic              write_done;
    logic              wea_a;       // strobe for memory a
    logic              wea_b;       // strobe for memory b
    logic [addr_w-1:0] write_addr;
    logic [elem_w-1:0] write_data;

    // same byte stream feeds both the decoder and the write path
    command_decoder u_command_decoder (
        .clk        (clk),
        .reset      (reset),
        .rx_ready   (rx_ready),
        .rx_data    (rx_data),
        .write_done (write_done),
        .op_done    (op_done),
        .command    (command),
        .write_en   (write_en),
        .start      (start),
        .busy       (busy)
    );

    write_ctrl #(
        .vec_len (vec_len)
    ) u_write_ctrl (
        .clk        (clk),
        .reset      (reset),
        .rx_ready   (rx_ready),
        .rx_data    (rx_data),
        .write_en   (write_en),
        .bram_sel   (command.bram_sel),  // memory chosen by bit 7 of the command
        .wea_a      (wea_a),
        .wea_b      (wea_b),
        .write_addr (write_addr),
        .write_data (write_data),
        .write_done (write_done)
    );

    vector_bram #(
        .vec_len (vec_len)
    ) bram_a (
        .clk        (clk),
        .we         (wea_a),
        .write_addr (write_addr),
        .write_data (write_data),
        .read_addr  (read_addr),
        .read_data  (bram_a_dout)
    );

    vector_bram #(
        .vec_len (vec_len)
    ) bram_b (
        .clk        (clk),
        .we         (wea_b),
        .write_addr (write_addr),
        .write_data (write_data),
        .read_addr  (read_addr),
        .read_data  (bram_b_dout)
    );

endmodule

//--- hw/vector_engine.sv
`timescale 1ns/100ps

module vector_engine
    import vector_pkg::*;
#(
    parameter int vec_len = 16,
    localparam int addr_w = $clog2(vec_len)
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              start,        // pulse from the decoder
    input  command_t          command,      // held stable until retire
    input  logic [elem_w-1:0] bram_a_dout,
    input  logic [elem_w-1:0] bram_b_dout,
    output logic [addr_w-1:0] read_addr,
    output result_t           result,
    output logic              op_done       // pulses with the last result
);

    logic                active;     // addresses being issued
    logic                rd_valid;   // memory outputs hold an element
    logic                rd_last;    // that element is the final one
    logic [elem_w-1:0]   sel_elem;   // element of the selected memory
    logic [elem_w-1:0]   abs_diff;   // |a - b|
    logic [result_w-1:0] term;       // contribution of the current element
    logic                per_elem;   // one result per element, no accumulation
    logic [result_w-1:0] acc;
    logic [result_w-1:0] res_data;
    logic                res_valid;
    logic                res_last;

    // address walk 0 .. vec_len-1
    always_ff @(posedge clk) begin
        if (reset) begin
            active    <= 1'b0;
            read_addr <= '0;
        end else if (start) begin
            active    <= 1'b1;
            read_addr <= '0;
        end else if (active) begin
            if (read_addr == addr_w'(vec_len - 1)) begin
                active    <= 1'b0;
                read_addr <= '0;
            end else begin
                read_addr <= read_addr + 1'b1;
            end
        end
    end

    // flags follow the one cycle read latency
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_valid <= 1'b0;
            rd_last  <= 1'b0;
        end else begin
            rd_valid <= active;
            rd_last  <= active && (read_addr == addr_w'(vec_len - 1));
        end
    end

    always_comb begin
        sel_elem = command.bram_sel ? bram_b_dout : bram_a_dout;
        abs_diff = (bram_a_dout > bram_b_dout) ? bram_a_dout - bram_b_dout
                                               : bram_b_dout - bram_a_dout;
        per_elem = command.opcode inside {op_read, op_sum};
        case (command.opcode)
            op_read: term = result_w'(sel_elem);
            op_sum:  term = result_w'(bram_a_dout) + result_w'(bram_b_dout);
            op_man:  term = result_w'(abs_diff);
            op_dot:  term = result_w'(bram_a_dout) * result_w'(bram_b_dout);  // 20 bit product
            default: term = '0;
        endcase
    end

    // running sum for manhattan and dot, restarted by each start pulse
    always_ff @(posedge clk) begin
        if (start) begin
            acc <= '0;
        end else if (rd_valid) begin
            acc <= acc + term;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_valid) begin
            res_data <= per_elem ? term : acc + term;  // final sum includes the last term
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            res_valid <= 1'b0;
            res_last  <= 1'b0;
            op_done   <= 1'b0;
        end else begin
            res_valid <= rd_valid && (per_elem || rd_last);
            res_last  <= rd_last;
            op_done   <= rd_last;  // decoder retires on this edge
        end
    end

    assign result = '{data: res_data, valid: res_valid, last: res_last};

endmodule

//--- hw/vector_unit_top.sv
`timescale 1ns/100ps

module vector_unit_top
    import vector_pkg::*;
#(
    parameter int vec_len = 16   // elements per vector
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       rx_ready,  // one cycle byte strobe
    input  logic [7:0] rx_data,
    output result_t    result,
    output logic       busy
);

    localparam int addr_w = $clog2(vec_len);

    command_t          command;
    logic              start;
    logic              op_done;
    logic [addr_w-1:0] read_addr;    // engine drives, both memories follow
    logic [elem_w-1:0] bram_a_dout;
    logic [elem_w-1:0] bram_b_dout;

    input_interface #(
        .vec_len (vec_len)
    ) u_input_interface (
        .clk         (clk),
        .reset       (reset),
        .rx_ready    (rx_ready),
        .rx_data     (rx_data),
        .read_addr   (read_addr),
        .op_done     (op_done),
        .command     (command),
        .start       (start),
        .busy        (busy),
        .bram_a_dout (bram_a_dout),
        .bram_b_dout (bram_b_dout)
    );

    vector_engine #(
        .vec_len (vec_len)
    ) u_vector_engine (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .command     (command),
        .bram_a_dout (bram_a_dout),
        .bram_b_dout (bram_b_dout),
        .read_addr   (read_addr),
        .result      (result),
        .op_done     (op_done)
    );

endmodule

//--- verification/vector_unit_assertions.sv
`timescale 1ns/100ps

module vector_unit_assertions
    import vector_pkg::*;
(
    input logic     clk,
    input logic     reset,
    input logic     wea_a,
    input logic     wea_b,
    input logic     start,
    input logic     write_done,
    input command_t command
);

    // each element lands in the memory picked by the command, never in both
    a_one_strobe: assert property (@(posedge clk) disable iff (reset)
                                   (wea_a || wea_b) |->
                                   (wea_a != wea_b) && (wea_b == command.bram_sel))
        else $error("write strobe on both memories or on the unselected one");

    a_start_pulse: assert property (@(posedge clk) disable iff (reset) start |=> !start)
        else $error("start held longer than one cycle");

    a_done_pulse: assert property (@(posedge clk) disable iff (reset)
                                   write_done |=> !write_done)
        else $error("write_done held longer than one cycle");

    // strobes only while a write command is active
    a_write_cmd: assert property (@(posedge clk) disable iff (reset)
                                  (wea_a || wea_b) |-> command.opcode == op_write)
        else $error("memory write outside a write command");

endmodule

bind input_interface vector_unit_assertions u_assertions (
    .clk        (clk),
    .reset      (reset),
    .wea_a      (wea_a),
    .wea_b      (wea_b),
    .start      (start),
    .write_done (write_done),
    .command    (command)
);

//--- verification/tb_vector_unit.sv
`timescale 1ns/100ps

module tb_vector_unit
    import vector_pkg::*;
;

    localparam int vec_len   = 4;    // short vectors keep the data file small
    localparam int max_lines = 256;

    logic       clk;
    logic       reset;
    logic       rx_ready;
    logic [7:0] rx_data;
    result_t    result;
    logic       busy;

    logic [31:0] lines [max_lines];  // kind in 31:28, payload below
    logic [24:0] expected [$];       // {last, data} in arrival order
    int          num_lines;
    int          cycle_limit = 0;    // zero until the data file is counted
    int          cycles = 0;
    integer      seed;

    vector_unit_top #(
        .vec_len (vec_len)
    ) dut (
        .clk      (clk),
        .reset    (reset),
        .rx_ready (rx_ready),
        .rx_data  (rx_data),
        .result   (result),
        .busy     (busy)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1, "run stopped at %0t", $time);
    endtask

    // strobe for one cycle, then one idle cycle before the next byte
    task automatic send_byte(input logic [7:0] value);
        @(negedge clk);
        rx_data  = value;
        rx_ready = 1'b1;
        @(negedge clk);
        rx_ready = 1'b0;
    endtask

    // wait for the decoder to drop busy, then poke it with a junk opcode
    task automatic wait_idle();
        logic [7:0] gap;
        @(negedge clk);
        assert (busy)  // command still in progress here
            else abort_run($sformatf("MISMATCH time=%0t busy got %0b expected %0b",
                                     $time, busy, 1'b1));
        while (busy) begin
            @(negedge clk);
        end
        assert (expected.size() == 0)
            else abort_run($sformatf("operation ended with %0d results missing",
                                     expected.size()));
        gap = 8'($random(seed));
        send_byte({gap[7:3], 3'b110});  // opcode 6 is never accepted
    endtask

    // results are stable away from the rising edge
    always @(negedge clk) begin : result_monitor
        logic [24:0] want;
        if (!reset && result.valid) begin
            assert (expected.size() > 0)
                else abort_run($sformatf("unexpected result %0h at %0t with nothing pending",
                                         result.data, $time));
            want = expected.pop_front();
            assert (result.data == want[23:0])
                else abort_run($sformatf("MISMATCH time=%0t result.data got %0h expected %0h",
                                         $time, result.data, want[23:0]));
            assert (result.last == want[24])
                else abort_run($sformatf("MISMATCH time=%0t result.last got %0b expected %0b",
                                         $time, result.last, want[24]));
            assert (!result.last || busy)  // busy drops one cycle after the last result
                else abort_run($sformatf("MISMATCH time=%0t busy got %0b expected %0b",
                                         $time, busy, 1'b1));
        end
    end

    always @(posedge clk) begin : watchdog
        cycles++;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            abort_run($sformatf("timeout, run still going after %0d cycles", cycles));
        end
    end

    initial begin
        seed     = 32'ha36e;
        reset    = 1'b1;
        rx_ready = 1'b0;
        rx_data  = 8'h00;
        foreach (lines[i]) begin
            lines[i] = '0;  // kind 0 marks unused entries
        end
        $readmemh("verification/vector_unit_testdata.txt", lines);
        num_lines = 0;
        foreach (lines[i]) begin
            if (lines[i][31:28] != 4'h0) begin
                num_lines++;
            end
        end
        cycle_limit = 40 * num_lines + 200;
        repeat (5) @(negedge clk);
        reset = 1'b0;

        for (int i = 0; i < max_lines; i++) begin
            case (lines[i][31:28])
                4'h1:    send_byte(lines[i][7:0]);
                4'h2:    expected.push_back(lines[i][24:0]);
                4'h3:    wait_idle();
                default: ;
            endcase
        end

        if (expected.size() != 0) begin
            abort_run($sformatf("%0d expected results never arrived", expected.size()));
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

//--- verification/vector_unit_testdata.txt
// kind in bits 31:28: 1 = send byte 7:0, 2 = expect result (last in bit 24, data 23:0)
// 3 = wait until busy is low, 0 or missing = end of data; vec_len is 4
10000001 // write a
10000005
100000A0 // upper bits of the high byte are dropped
100000FF
10000003
1000002C
10000001
100000BC
10000002
30000000
10000081 // write b
10000009
10000000
100000FF
100000FF
10000064
10000000
10000020
10000003
30000000
10000002 // read a
20000005
200003FF
2000012C
210002BC
30000000
10000082 // read b
20000009
200003FF
20000064
21000320
30000000
10000003 // sum
2000000E
200007FE
20000190
210005DC
30000000
10000004 // manhattan 4 + 0 + 200 + 100
21000130
30000000
10000005 // dot with 1023 * 1023
2118F8DE
30000000
10000006 // unused opcodes, no results
10000087
10000081 // rewrite b
100000FF
10000003
10000000
10000000
100000A5
10000002
1000005A
10000001
30000000
10000082 // read b again
200003FF
20000000
200002A5
2100015A
30000000

//--- files.f
hw/vector_pkg.sv
hw/write_ctrl.sv
hw/command_decoder.sv
hw/vector_bram.sv
hw/input_interface.sv
hw/vector_engine.sv
hw/vector_unit_top.sv
verification/vector_unit_assertions.sv
verification/tb_vector_unit.sv

//--- Bender.yml
package:
  name: vector_unit

sources:
  - files:
      - hw/vector_pkg.sv
      - hw/write_ctrl.sv
      - hw/command_decoder.sv
      - hw/vector_bram.sv
      - hw/input_interface.sv
      - hw/vector_engine.sv
      - hw/vector_unit_top.sv
  - target: test
    files:
      - verification/vector_unit_assertions.sv
      - verification/tb_vector_unit.sv
